// ==== Bender.yml ====
package:
  name: ualink_turbo

sources:
  - hdl/ualink_stream_pkg.sv
  - hdl/ualink_cmd_pkg.sv
  - hdl/ingress_fifo.sv
  - hdl/queue_arbiter.sv
  - hdl/command_store.sv
  - hdl/command_engine.sv
  - hdl/ualink_turbo.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_ualink_turbo.sv

// ==== hdl/command_engine.sv ====
// command decode on the egress word; a read waits one cycle for its lookup, other words pass at once

module command_engine (
   input  logic                                        axi_aclk,
   input  logic                                        axi_resetn,
   input  ualink_stream_pkg::beat_t                    head_beat,
   input  logic                                        head_valid,
   output logic                                        head_pop,
   output ualink_stream_pkg::beat_t                    m_axis_beat,
   output logic                                        m_axis_tvalid,
   input  logic                                        m_axis_tready,
   output logic                                        store_wr_en,
   output logic                                        store_rd_en,
   output logic [ualink_cmd_pkg::store_addr_width-1:0] store_addr,
   output ualink_cmd_pkg::cmd_word_u                   store_wr_data,
   input  ualink_cmd_pkg::cmd_word_u                   store_rd_data
);

   ualink_cmd_pkg::cmd_word_u head_cmd;

   logic is_write;
   logic is_read;
   logic lookup_done;   // rd_data already holds this read's entry
   logic accept;

   // head word seen as a command
   assign head_cmd.raw = head_beat.data;

   assign is_write = head_valid && (head_cmd.fields.opcode == ualink_cmd_pkg::op_write);
   assign is_read  = head_valid && (head_cmd.fields.opcode == ualink_cmd_pkg::op_read);

   // reads stay off the egress during the lookup cycle
   assign m_axis_tvalid = head_valid && (!is_read || lookup_done);
   assign accept        = m_axis_tvalid && m_axis_tready;
   assign head_pop      = accept;

   // write lands once, on acceptance, so stalls do not repeat it
   assign store_wr_en   = accept && is_write;
   assign store_rd_en   = is_read && !lookup_done;   // one lookup per read word
   assign store_addr    = head_cmd.fields.addr;
   assign store_wr_data = head_cmd;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         lookup_done <= 1'b0;
      end else if (accept) begin
         lookup_done <= 1'b0;
      end else if (store_rd_en) begin
         lookup_done <= 1'b1;
      end
   end

   // reads carry the stored word, keep and last come from the read itself
   always_comb begin
      m_axis_beat = head_beat;
      if (is_read) begin
         m_axis_beat.data = store_rd_data.raw;
      end
   end

   // AXI-Stream hold rule, relies on the arbiter keeping the grant and the store holding rd_data
   a_beat_stable : assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_beat))
   );

endmodule

// ==== hdl/command_store.sv ====
// 256 x 64 command store, cleared by reset; read data is registered and holds between reads

module command_store (
   input  logic                                        axi_aclk,
   input  logic                                        axi_resetn,
   input  logic                                        wr_en,
   input  logic [ualink_cmd_pkg::store_addr_width-1:0] wr_addr,
   input  ualink_cmd_pkg::cmd_word_u                   wr_data,
   input  logic                                        rd_en,
   input  logic [ualink_cmd_pkg::store_addr_width-1:0] rd_addr,
   output ualink_cmd_pkg::cmd_word_u                   rd_data
);

   logic [ualink_stream_pkg::data_width-1:0] mem [ualink_cmd_pkg::store_depth];

   // register file, every entry reads back zero after reset
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         for (int i = 0; i < ualink_cmd_pkg::store_depth; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_addr] <= wr_data.raw;
      end
   end

   // one cycle lookup, value kept until the next rd_en
   always_ff @(posedge axi_aclk) begin
      if (rd_en) begin
         rd_data.raw <= mem[rd_addr];
      end
   end

endmodule

// ==== hdl/ingress_fifo.sv ====
// fall-through FIFO of 2**fifo_depth_bits words; nearly_full rises with two free entries left

module ingress_fifo #(
   parameter int fifo_depth_bits = 4
) (
   input  logic                     axi_aclk,
   input  logic                     axi_resetn,
   input  ualink_stream_pkg::beat_t wr_beat,
   input  logic                     wr_en,
   input  logic                     rd_en,
   output ualink_stream_pkg::beat_t head,
   output logic                     empty,
   output logic                     nearly_full
);

   localparam int depth = 1 << fifo_depth_bits;

   ualink_stream_pkg::beat_t mem [depth];

   logic [fifo_depth_bits-1:0] wr_ptr;
   logic [fifo_depth_bits-1:0] rd_ptr;
   logic [fifo_depth_bits:0]   count;   // one extra bit to tell full from empty
   logic                       full;

   // storage, written behind the write pointer
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_beat;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   assign head        = mem[rd_ptr];   // fall-through, no read latency
   assign empty       = (count == '0);
   assign full        = (count == depth[fifo_depth_bits:0]);
   assign nearly_full = (count >= (depth[fifo_depth_bits:0] - 2'd2));

   // upstream ready and downstream pop must respect the occupancy
   a_no_write_full : assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn) wr_en |-> !full
   );

   a_no_read_empty : assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn) rd_en |-> !empty
   );

endmodule

// ==== hdl/queue_arbiter.sv ====
// round-robin packet arbiter; a grant lasts a whole packet, a stalled packet blocks the others

module queue_arbiter #(
   parameter int num_queues = 2
) (
   input  logic                     axi_aclk,
   input  logic                     axi_resetn,
   input  ualink_stream_pkg::beat_t heads [num_queues],
   input  logic [num_queues-1:0]    empties,
   output ualink_stream_pkg::beat_t head_beat,
   output logic                     head_valid,
   input  logic                     head_pop,
   output logic [num_queues-1:0]    pops
);

   localparam int sel_width = (num_queues > 1) ? $clog2(num_queues) : 1;

   logic [sel_width-1:0] cur_queue;
   logic [sel_width-1:0] next_queue;
   logic                 in_packet;   // first word popped, last not yet
   logic                 last_pop;
   logic                 advance;

   // granted head to the engine, pop back to the same queue
   assign head_beat  = heads[cur_queue];
   assign head_valid = !empties[cur_queue];

   always_comb begin
      pops            = '0;
      pops[cur_queue] = head_pop;
   end

   assign last_pop = head_pop && head_beat.last;
   assign advance  = last_pop || (!in_packet && empties[cur_queue]);

   // nearest non-empty queue above the current one, wrapping; stay if none
   always_comb begin
      int cand;
      next_queue = cur_queue;
      for (int k = num_queues - 1; k >= 1; k--) begin
         cand = int'(cur_queue) + k;
         if (cand >= num_queues) begin
            cand = cand - num_queues;
         end
         if (!empties[cand]) begin
            next_queue = sel_width'(cand);   // smaller k wins
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         cur_queue <= '0;
         in_packet <= 1'b0;
      end else begin
         if (advance) begin
            cur_queue <= next_queue;
         end
         if (head_pop) begin
            in_packet <= !head_beat.last;
         end
      end
   end

   // packets from different queues never interleave on the egress, from the first pop on
   a_grant_held : assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      ((in_packet || head_pop) && !last_pop) |=> $stable(cur_queue)
   );

endmodule

// ==== hdl/ualink_cmd_pkg.sv ====
// command word layout and opcodes; compile after ualink_stream_pkg, only 0xEF and 0xEE are decoded

package ualink_cmd_pkg;

   // opcodes carried in bits 15..8
   parameter logic [7:0] op_write = 8'hEF;   // store the word, forward it unchanged
   parameter logic [7:0] op_read  = 8'hEE;   // forward the store entry instead

   // command store geometry
   parameter int store_addr_width = 8;
   parameter int store_depth      = 1 << store_addr_width;

   // addr, opcode and flags are one byte each
   parameter int field_width = 8;

   // command fields, msb first
   typedef struct packed {
      logic [ualink_stream_pkg::data_width-3*field_width-1:0] payload;  // 63..24
      logic [store_addr_width-1:0]                            addr;     // 23..16
      logic [field_width-1:0]                                 opcode;   // 15..8
      logic [field_width-1:0]                                 flags;    // 7..0
   } cmd_fields_t;

   // the same egress word, seen as plain data or as a command
   typedef union packed {
      logic [ualink_stream_pkg::data_width-1:0] raw;
      cmd_fields_t                              fields;
   } cmd_word_u;

endpackage

// ==== hdl/ualink_stream_pkg.sv ====
// stream word layout shared by all queues and the egress port; 64-bit data only, no tuser

package ualink_stream_pkg;

   // word width on every ingress queue and on the egress port
   parameter int data_width = 64;

   // one keep bit per data byte
   parameter int keep_width = data_width / 8;

   // one stream word, handshake travels separately
   typedef struct packed {
      logic [data_width-1:0] data;   // command word or payload
      logic [keep_width-1:0] keep;   // byte qualifiers, passed through untouched
      logic                  last;   // end of packet
   } beat_t;

endpackage

// ==== hdl/ualink_turbo.sv ====
// command forwarder top; num_queues ingress streams to one egress, tready drops near FIFO full

module ualink_turbo #(
   parameter int num_queues      = 2,
   parameter int fifo_depth_bits = 4
) (
   input  logic                     axi_aclk,
   input  logic                     axi_resetn,
   input  ualink_stream_pkg::beat_t s_axis_beat [num_queues],
   input  logic [num_queues-1:0]    s_axis_tvalid,
   output logic [num_queues-1:0]    s_axis_tready,
   output ualink_stream_pkg::beat_t m_axis_beat,
   output logic                     m_axis_tvalid,
   input  logic                     m_axis_tready
);

   ualink_stream_pkg::beat_t fifo_head [num_queues];

   logic [num_queues-1:0] fifo_empty;
   logic [num_queues-1:0] fifo_nearly_full;
   logic [num_queues-1:0] fifo_pop;

   ualink_stream_pkg::beat_t head_beat;
   logic                     head_valid;
   logic                     head_pop;

   logic                                        store_wr_en;
   logic                                        store_rd_en;
   logic [ualink_cmd_pkg::store_addr_width-1:0] store_addr;
   ualink_cmd_pkg::cmd_word_u                   store_wr_data;
   ualink_cmd_pkg::cmd_word_u                   store_rd_data;

   assign s_axis_tready = ~fifo_nearly_full;

   for (genvar i = 0; i < num_queues; i++) begin : g_queue
      ingress_fifo #(
         .fifo_depth_bits (fifo_depth_bits)
      ) i_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .wr_beat     (s_axis_beat[i]),
         .wr_en       (s_axis_tvalid[i] & s_axis_tready[i]),   // plain handshake
         .rd_en       (fifo_pop[i]),
         .head        (fifo_head[i]),
         .empty       (fifo_empty[i]),
         .nearly_full (fifo_nearly_full[i])
      );
   end

   queue_arbiter #(
      .num_queues (num_queues)
   ) i_arbiter (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .heads      (fifo_head),
      .empties    (fifo_empty),
      .head_beat  (head_beat),
      .head_valid (head_valid),
      .head_pop   (head_pop),
      .pops       (fifo_pop)
   );

   command_engine i_engine (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .head_beat     (head_beat),
      .head_valid    (head_valid),
      .head_pop      (head_pop),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .store_wr_en   (store_wr_en),
      .store_rd_en   (store_rd_en),
      .store_addr    (store_addr),
      .store_wr_data (store_wr_data),
      .store_rd_data (store_rd_data)
   );

   // one address serves both ports, never written and read in the same cycle
   command_store i_store (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .wr_en      (store_wr_en),
      .wr_addr    (store_addr),
      .wr_data    (store_wr_data),
      .rd_en      (store_rd_en),
      .rd_addr    (store_addr),
      .rd_data    (store_rd_data)
   );

endmodule

// ==== sim/tb_ualink_tasks.svh ====
// tasks of tb_ualink_turbo, included inside the module and using its signals and queues
`ifndef TB_UALINK_TASKS_SVH
`define TB_UALINK_TASKS_SVH

task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                           input string what);
   if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
   end
endtask

function automatic ualink_stream_pkg::beat_t make_word(
   input logic [39:0] payload, input logic [7:0] addr, input logic [7:0] opcode,
   input logic [7:0] flags, input logic [7:0] keep, input logic last);
   ualink_cmd_pkg::cmd_word_u cmd;
   ualink_stream_pkg::beat_t  b;
   cmd.fields.payload = payload;
   cmd.fields.addr    = addr;
   cmd.fields.opcode  = opcode;
   cmd.fields.flags   = flags;
   b.data = cmd.raw;
   b.keep = keep;
   b.last = last;
   return b;
endfunction

// egress word predicted from the opcode rules, in egress order
task automatic add_expected(input ualink_stream_pkg::beat_t w);
   ualink_cmd_pkg::cmd_word_u cmd;
   ualink_stream_pkg::beat_t  e;
   cmd.raw = w.data;
   e       = w;
   if (cmd.fields.opcode == ualink_cmd_pkg::op_write) begin
      model_store[cmd.fields.addr] = cmd.raw;
   end else if (cmd.fields.opcode == ualink_cmd_pkg::op_read) begin
      e.data = model_store[cmd.fields.addr];   // keep and last of the read word stay
   end
   exp_q.push_back(e);
endtask

task automatic send_word(input int q, input ualink_stream_pkg::beat_t w);
   bit taken;
   @(negedge axi_aclk);
   s_axis_beat[q]   = w;
   s_axis_tvalid[q] = 1'b1;
   taken = 1'b0;
   while (!taken) begin
      @(posedge axi_aclk);
      taken = s_axis_tready[q];   // ready as seen at this edge
   end
   in_count[q]++;
endtask

task automatic send_packet(input int q, input ualink_stream_pkg::beat_t words [$]);
   foreach (words[i]) begin
      send_word(q, words[i]);
   end
   @(negedge axi_aclk);
   s_axis_tvalid[q] = 1'b0;
endtask

// plain words, opcode 0x20, tagged by packet
function automatic ualink_stream_pkg::beat_t tagged_word(input logic [7:0] tag, input int i,
                                                         input int len);
   return make_word({tag, 32'(i)}, 8'(i), 8'h20, tag, 8'hFF, i == len - 1);
endfunction

task automatic load_packet(input int q, input logic [7:0] tag, input int len);
   ualink_stream_pkg::beat_t words [$];
   for (int i = 0; i < len; i++) begin
      words.push_back(tagged_word(tag, i, len));
   end
   send_packet(q, words);
endtask

task automatic expect_packet(input logic [7:0] tag, input int len);
   for (int i = 0; i < len; i++) begin
      add_expected(tagged_word(tag, i, len));
   end
endtask

// a few idle cycles after the count so extra words show up too
task automatic wait_for_words(input int n);
   while (got_q.size() < n) begin
      @(negedge axi_aclk);
   end
   repeat (4) @(negedge axi_aclk);
endtask

task automatic check_stream(input string what);
   check_equal(got_q.size(), exp_q.size(), {what, ": egress word count"});
   foreach (exp_q[i]) begin
      check_equal(got_q[i], exp_q[i], $sformatf("%s: egress word %0d", what, i));
   end
   got_q.delete();
   exp_q.delete();
endtask

task automatic pass_through();
   ualink_stream_pkg::beat_t words [$];
   words.push_back(make_word(40'h01_0203_0405, 8'h11, 8'h01, 8'h00, 8'hFF, 1'b0));
   words.push_back(make_word(40'hA0_B0C0_D0E0, 8'h05, 8'h10, 8'h3C, 8'hFF, 1'b0));
   words.push_back(make_word(40'h55_AA55_AA55, 8'h22, 8'hEA, 8'h81, 8'hFF, 1'b0));
   words.push_back(make_word(40'hFF_0000_FFFF, 8'h05, 8'h00, 8'h7E, 8'h3F, 1'b1));
   foreach (words[i]) begin
      add_expected(words[i]);
   end
   send_packet(0, words);
   wait_for_words(words.size());
   check_stream("pass-through");
endtask

task automatic write_then_read();
   ualink_stream_pkg::beat_t wr [$];
   ualink_stream_pkg::beat_t rd [$];
   wr.push_back(make_word(40'h12_3456_789A, 8'h05, ualink_cmd_pkg::op_write, 8'h5A, 8'hFF, 1'b1));
   rd.push_back(make_word(40'h00_0000_0000, 8'h05, ualink_cmd_pkg::op_read, 8'h00, 8'h0F, 1'b1));
   add_expected(wr[0]);
   add_expected(rd[0]);
   send_packet(0, wr);
   send_packet(0, rd);
   wait_for_words(2);
   check_stream("write then read of 0x05");
endtask

task automatic reset_contents();
   ualink_stream_pkg::beat_t rd [$];
   rd.push_back(make_word(40'hDE_ADBE_EF00, 8'h77, ualink_cmd_pkg::op_read, 8'h01, 8'hF0, 1'b1));
   add_expected(rd[0]);
   send_packet(0, rd);
   wait_for_words(1);
   check_equal(got_q[0].data, 64'h0, "unwritten address 0x77 reads zero");
   check_stream("read of an unwritten address");
endtask

// both queues loaded behind a stalled egress, then released
task automatic packet_arbitration();
   @(negedge axi_aclk);
   m_axis_tready = 1'b0;
   load_packet(0, 8'hA0, 3);
   load_packet(0, 8'hA1, 3);
   load_packet(1, 8'hB0, 2);
   load_packet(1, 8'hB1, 2);
   expect_packet(8'hA0, 3);   // whole packets, turns alternate
   expect_packet(8'hB0, 2);
   expect_packet(8'hA1, 3);
   expect_packet(8'hB1, 2);
   @(negedge axi_aclk);
   m_axis_tready = 1'b1;
   wait_for_words(10);
   check_stream("round-robin arbitration");
endtask

task automatic random_stall();
   ualink_stream_pkg::beat_t words [$];
   words.push_back(make_word(40'h11_1111_1111, 8'h20, ualink_cmd_pkg::op_write, 8'h01, 8'hFF, 1'b0));
   words.push_back(make_word(40'h22_2222_2222, 8'h30, 8'h44, 8'h02, 8'hFF, 1'b0));
   words.push_back(make_word(40'h33_3333_3333, 8'h21, ualink_cmd_pkg::op_write, 8'h03, 8'hFF, 1'b0));
   words.push_back(make_word(40'h0, 8'h20, ualink_cmd_pkg::op_read, 8'h04, 8'hFF, 1'b0));
   words.push_back(make_word(40'h44_4444_4444, 8'h20, ualink_cmd_pkg::op_write, 8'h05, 8'hFF, 1'b0));
   words.push_back(make_word(40'h0, 8'h20, ualink_cmd_pkg::op_read, 8'h06, 8'h0F, 1'b0));
   words.push_back(make_word(40'h0, 8'h21, ualink_cmd_pkg::op_read, 8'h07, 8'hFF, 1'b0));
   words.push_back(make_word(40'h55_5555_5555, 8'h30, 8'h45, 8'h08, 8'h01, 1'b1));
   foreach (words[i]) begin
      add_expected(words[i]);
   end
   fork
      send_packet(0, words);
   join_none
   while (got_q.size() < words.size()) begin
      @(negedge axi_aclk);
      m_axis_tready = ($urandom % 2 == 1);   // random stalls on the egress
   end
   m_axis_tready = 1'b1;
   wait fork;
   wait_for_words(words.size());
   check_stream("random egress stalls");
endtask

task automatic ingress_flow_control();
   int accepted;
   @(negedge axi_aclk);
   m_axis_tready = 1'b0;
   in_count[0]   = 0;
   fork
      load_packet(0, 8'hC0, 16);
   join_none
   while (s_axis_tready[0]) begin
      @(posedge axi_aclk);
   end
   @(negedge axi_aclk);
   accepted = in_count[0];
   check_equal(accepted < 16, 1'b1, "queue 0 ready dropped before 16 words");
   check_equal(accepted, 14, "words accepted with two free entries left");
   repeat (3) @(negedge axi_aclk);
   check_equal(in_count[0], accepted, "no word taken while queue 0 is not ready");
   check_equal(m_axis_tvalid, 1'b1, "egress word offered while tready is low");
   check_equal(m_axis_beat, tagged_word(8'hC0, 0, 16), "first word held on the egress");
   m_axis_tready = 1'b1;
   wait fork;
   expect_packet(8'hC0, 16);
   wait_for_words(16);
   check_stream("ingress flow control");
endtask

`endif

// ==== sim/tb_ualink_turbo.sv ====
// directed testbench for ualink_turbo with 2 queues of 16 words; the first mismatch ends the run

module tb_ualink_turbo;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_queues      = 2;
   localparam int fifo_depth_bits = 4;
   localparam int words_driven    = 41;   // sum of all words sent by the tests below
   localparam int timeout_cycles  = 20 * words_driven + 1000;

   logic                     axi_aclk;
   logic                     axi_resetn;
   ualink_stream_pkg::beat_t s_axis_beat [num_queues];
   logic [num_queues-1:0]    s_axis_tvalid;
   logic [num_queues-1:0]    s_axis_tready;
   ualink_stream_pkg::beat_t m_axis_beat;
   logic                     m_axis_tvalid;
   logic                     m_axis_tready;

   ualink_stream_pkg::beat_t got_q [$];   // words taken from the egress
   ualink_stream_pkg::beat_t exp_q [$];   // words the rules predict
   logic [63:0]              model_store [256];
   int                       in_count [num_queues];   // words accepted per queue
   int                       cycle_count;

   `include "tb_ualink_tasks.svh"

   ualink_turbo #(
      .num_queues      (num_queues),
      .fifo_depth_bits (fifo_depth_bits)
   ) i_dut (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_beat   (s_axis_beat),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   always #4 axi_aclk = ~axi_aclk;   // 8 ns period

   // egress monitor, values seen here are the ones before the edge
   always @(posedge axi_aclk) begin
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         got_q.push_back(m_axis_beat);
      end
   end

   always @(posedge axi_aclk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
         $display("Test FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   initial begin
      void'($urandom(54116));
      axi_aclk      = 1'b0;
      axi_resetn    = 1'b0;
      s_axis_tvalid = '0;
      m_axis_tready = 1'b1;
      cycle_count   = 0;
      for (int q = 0; q < num_queues; q++) begin
         s_axis_beat[q] = '0;
         in_count[q]    = 0;
      end
      for (int a = 0; a < 256; a++) begin
         model_store[a] = '0;   // store is cleared by reset
      end
      repeat (3) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_resetn = 1'b1;

      check_equal(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
      check_equal(s_axis_tready, 2'b11, "s_axis_tready after reset");

      pass_through();
      write_then_read();
      reset_contents();
      packet_arbitration();
      random_stall();
      ingress_flow_control();

      $display("Test OK");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+sim
hdl/ualink_stream_pkg.sv
hdl/ualink_cmd_pkg.sv
hdl/ingress_fifo.sv
hdl/queue_arbiter.sv
hdl/command_store.sv
hdl/command_engine.sv
hdl/ualink_turbo.sv
sim/tb_ualink_turbo.sv
